// ==== verilog/sys_pkg.sv ====
// address map, bus widths and device encoding of the memory-bus subsystem
// imported with a wildcard by every module and by the testbench
`default_nettype none

package sys_pkg;

  // bus widths
  localparam int ADDR_WIDTH = 32;
  localparam int DATA_WIDTH = 32;
  localparam int BE_WIDTH   = DATA_WIDTH / 8;

  // ram window, 64 KiB
  localparam logic [31:0] MEM_START = 32'h0010_0000;
  localparam logic [31:0] MEM_SIZE  = 32'h0001_0000;
  localparam logic [31:0] MEM_MASK  = ~(MEM_SIZE - 32'd1);

  // gpio window, 4 KiB
  localparam logic [31:0] GPIO_START = 32'h8000_0000;
  localparam logic [31:0] GPIO_SIZE  = 32'h0000_1000;
  localparam logic [31:0] GPIO_MASK  = ~(GPIO_SIZE - 32'd1);

  // ram geometry in words
  localparam int RAM_DEPTH = int'(MEM_SIZE / 32'd4);
  localparam int RAM_AW    = $clog2(RAM_DEPTH);

  // gpio pin counts
  localparam int GPI_WIDTH = 8;
  localparam int GPO_WIDTH = 16;

  // register offsets inside the gpio window
  localparam int GPO_OFFSET = 0;
  localparam int GPI_OFFSET = 4;

  // target of a data request
  // dev_none means no window matched, answered with an error
  typedef enum logic [1:0] {
    dev_ram  = 2'd0,
    dev_gpio = 2'd1,
    dev_none = 2'd2
  } bus_device_e;

endpackage

`default_nettype wire

// ==== verilog/gpio.sv ====
// gpio block on the data bus
// one output register with byte enables, one readable input register
`timescale 1ns/1ps
`default_nettype none

module gpio
  import sys_pkg::*;
(
  input  wire logic                  clk_sys_i,
  input  wire logic                  rst_sys_ni,

  // bus side
  input  wire logic                  req_i,
  input  wire logic [ADDR_WIDTH-1:0] addr_i,
  input  wire logic                  we_i,
  input  wire logic [BE_WIDTH-1:0]   be_i,
  input  wire logic [DATA_WIDTH-1:0] wdata_i,
  output logic                       rvalid_o,
  output logic [DATA_WIDTH-1:0]      rdata_o,

  // pins
  input  wire logic [GPI_WIDTH-1:0]  gp_i,
  output logic [GPO_WIDTH-1:0]       gp_o
);

  logic [ADDR_WIDTH-1:0] offset;
  logic                  sel_gpo;
  logic                  sel_gpi;

  // offset inside the 4 KiB window
  assign offset  = addr_i & ~GPIO_MASK;
  assign sel_gpo = offset == ADDR_WIDTH'(GPO_OFFSET);
  assign sel_gpi = offset == ADDR_WIDTH'(GPI_OFFSET);

  // output register
  // only the low bytes exist, upper enables have nothing to hit
  always_ff @(posedge clk_sys_i or negedge rst_sys_ni) begin
    if (!rst_sys_ni) begin
      gp_o <= '0;
    end else if (req_i && we_i && sel_gpo) begin
      for (int i = 0; i < GPO_WIDTH / 8; i++) begin
        if (be_i[i]) begin
          gp_o[8*i +: 8] <= wdata_i[8*i +: 8];
        end
      end
    end
  end

  // read mux, unknown offsets read zero
  always_ff @(posedge clk_sys_i) begin
    if (req_i) begin
      if (sel_gpo) begin
        rdata_o <= DATA_WIDTH'(gp_o);
      end else if (sel_gpi) begin
        rdata_o <= DATA_WIDTH'(gp_i);
      end else begin
        rdata_o <= '0;
      end
    end
  end

  // one response per request
  always_ff @(posedge clk_sys_i or negedge rst_sys_ni) begin
    if (!rst_sys_ni) begin
      rvalid_o <= 1'b0;
    end else begin
      rvalid_o <= req_i;
    end
  end

endmodule

`default_nettype wire

// ==== verilog/ram_2p.sv ====
// 64 KiB dual-port word ram
// port a serves the data bus with byte writes, port b serves fetches read-only
`timescale 1ns/1ps
`default_nettype none

module ram_2p
  import sys_pkg::*;
(
  input  wire logic                  clk_sys_i,
  input  wire logic                  rst_sys_ni,

  // port a, data
  input  wire logic                  a_req_i,
  input  wire logic                  a_we_i,
  input  wire logic [BE_WIDTH-1:0]   a_be_i,
  input  wire logic [ADDR_WIDTH-1:0] a_addr_i,
  input  wire logic [DATA_WIDTH-1:0] a_wdata_i,
  output logic                       a_rvalid_o,
  output logic [DATA_WIDTH-1:0]      a_rdata_o,

  // port b, fetch
  input  wire logic                  b_req_i,
  input  wire logic [ADDR_WIDTH-1:0] b_addr_i,
  output logic [DATA_WIDTH-1:0]      b_rdata_o
);

  logic [DATA_WIDTH-1:0] mem [RAM_DEPTH];

  logic [RAM_AW-1:0] a_idx;
  logic [RAM_AW-1:0] b_idx;

  // word index, byte offset bits dropped
  // upper bits already matched by the decoders
  assign a_idx = a_addr_i[RAM_AW+1:2];
  assign b_idx = b_addr_i[RAM_AW+1:2];

  // port a
  // old word captured before the write lands, so read-first
  always_ff @(posedge clk_sys_i) begin
    if (a_req_i) begin
      a_rdata_o <= mem[a_idx];
      if (a_we_i) begin
        for (int i = 0; i < BE_WIDTH; i++) begin
          if (a_be_i[i]) begin
            mem[a_idx][8*i +: 8] <= a_wdata_i[8*i +: 8];
          end
        end
      end
    end
  end

  // port a response strobe, writes answer too
  always_ff @(posedge clk_sys_i or negedge rst_sys_ni) begin
    if (!rst_sys_ni) begin
      a_rvalid_o <= 1'b0;
    end else begin
      a_rvalid_o <= a_req_i;
    end
  end

  // port b
  // sees the pre-edge word even when port a writes the same index
  always_ff @(posedge clk_sys_i) begin
    if (b_req_i) begin
      b_rdata_o <= mem[b_idx];
    end
  end

endmodule

`default_nettype wire

// ==== verilog/instr_fetch.sv ====
// instruction-fetch path, only the ram window may be fetched from
// grants in-window fetches and returns their valid one cycle later
`timescale 1ns/1ps
`default_nettype none

module instr_fetch
  import sys_pkg::*;
(
  input  wire logic                  clk_sys_i,
  input  wire logic                  rst_sys_ni,

  input  wire logic                  instr_req_i,
  input  wire logic [ADDR_WIDTH-1:0] instr_addr_i,
  output logic                       instr_gnt_o,
  output logic                       instr_rvalid_o,

  // read strobe for ram port b
  output logic                       ram_req_o
);

  logic in_ram;

  // window check
  assign in_ram = (instr_addr_i & MEM_MASK) == MEM_START;

  // out-of-window fetches stay ungranted, host keeps holding them
  assign ram_req_o   = instr_req_i & in_ram;
  assign instr_gnt_o = ram_req_o;

  // data comes from the ram read register, valid lines up with it
  always_ff @(posedge clk_sys_i or negedge rst_sys_ni) begin
    if (!rst_sys_ni) begin
      instr_rvalid_o <= 1'b0;
    end else begin
      instr_rvalid_o <= ram_req_o;
    end
  end

endmodule

`default_nettype wire

// ==== verilog/data_bus.sv ====
// data-side interconnect for a single host
// decodes each request onto the ram or the gpio and merges the responses
`timescale 1ns/1ps
`default_nettype none

module data_bus
  import sys_pkg::*;
(
  input  wire logic                  clk_sys_i,
  input  wire logic                  rst_sys_ni,

  // host side
  input  wire logic                  data_req_i,
  input  wire logic [ADDR_WIDTH-1:0] data_addr_i,
  input  wire logic                  data_we_i,
  input  wire logic [BE_WIDTH-1:0]   data_be_i,
  input  wire logic [DATA_WIDTH-1:0] data_wdata_i,
  output logic                       data_gnt_o,
  output logic                       data_rvalid_o,
  output logic [DATA_WIDTH-1:0]      data_rdata_o,
  output logic                       data_err_o,

  // device responses
  input  wire logic                  ram_rvalid_i,
  input  wire logic [DATA_WIDTH-1:0] ram_rdata_i,
  input  wire logic                  gpio_rvalid_i,
  input  wire logic [DATA_WIDTH-1:0] gpio_rdata_i,

  // device requests
  output logic                       ram_req_o,
  output logic                       gpio_req_o,
  output logic [ADDR_WIDTH-1:0]      dev_addr_o,
  output logic                       dev_we_o,
  output logic [BE_WIDTH-1:0]        dev_be_o,
  output logic [DATA_WIDTH-1:0]      dev_wdata_o
);

  bus_device_e dev_sel;
  bus_device_e dev_sel_q;
  logic        err_pending_q;

  // address decode against base and mask
  // ram checked first, windows do not overlap anyway
  always_comb begin
    dev_sel = dev_none;
    if ((data_addr_i & MEM_MASK) == MEM_START) begin
      dev_sel = dev_ram;
    end else if ((data_addr_i & GPIO_MASK) == GPIO_START) begin
      dev_sel = dev_gpio;
    end
  end

  // no back-pressure, every request granted at once
  assign data_gnt_o = data_req_i;

  // at most one device strobe
  assign ram_req_o  = data_req_i & (dev_sel == dev_ram);
  assign gpio_req_o = data_req_i & (dev_sel == dev_gpio);

  // payload shared by both devices
  assign dev_addr_o  = data_addr_i;
  assign dev_we_o    = data_we_i;
  assign dev_be_o    = data_be_i;
  assign dev_wdata_o = data_wdata_i;

  // remember the target for the response cycle
  // idle cycles park on dev_none with nothing pending
  always_ff @(posedge clk_sys_i or negedge rst_sys_ni) begin
    if (!rst_sys_ni) begin
      dev_sel_q     <= dev_none;
      err_pending_q <= 1'b0;
    end else begin
      dev_sel_q     <= data_req_i ? dev_sel : dev_none;
      err_pending_q <= data_req_i & (dev_sel == dev_none);
    end
  end

  // response merge
  always_comb begin
    data_rvalid_o = 1'b0;
    data_rdata_o  = '0;
    data_err_o    = 1'b0;
    case (dev_sel_q)
      dev_ram: begin
        data_rvalid_o = ram_rvalid_i;
        data_rdata_o  = ram_rdata_i;
      end
      dev_gpio: begin
        data_rvalid_o = gpio_rvalid_i;
        data_rdata_o  = gpio_rdata_i;
      end
      default: begin
        // unmapped access, error with zero data
        data_rvalid_o = err_pending_q;
        data_err_o    = err_pending_q;
      end
    endcase
  end

endmodule

`default_nettype wire

// ==== verilog/demo_system_top.sv ====
// top of the memory-bus subsystem, host ports come straight from the pins
// data host reaches ram and gpio, fetch port reaches ram port b only
`timescale 1ns/1ps
`default_nettype none

module demo_system_top
  import sys_pkg::*;
(
  input  wire logic                  clk_sys_i,
  input  wire logic                  rst_sys_ni,

  // data host port
  input  wire logic                  data_req_i,
  input  wire logic [ADDR_WIDTH-1:0] data_addr_i,
  input  wire logic                  data_we_i,
  input  wire logic [BE_WIDTH-1:0]   data_be_i,
  input  wire logic [DATA_WIDTH-1:0] data_wdata_i,
  output logic                       data_gnt_o,
  output logic                       data_rvalid_o,
  output logic [DATA_WIDTH-1:0]      data_rdata_o,
  output logic                       data_err_o,

  // fetch port
  input  wire logic                  instr_req_i,
  input  wire logic [ADDR_WIDTH-1:0] instr_addr_i,
  output logic                       instr_gnt_o,
  output logic                       instr_rvalid_o,
  output logic [DATA_WIDTH-1:0]      instr_rdata_o,

  // gpio pins
  input  wire logic [GPI_WIDTH-1:0]  gp_i,
  output logic [GPO_WIDTH-1:0]       gp_o
);

  // shared device payload
  logic [ADDR_WIDTH-1:0] dev_addr;
  logic                  dev_we;
  logic [BE_WIDTH-1:0]   dev_be;
  logic [DATA_WIDTH-1:0] dev_wdata;

  // per-device strobes and responses
  logic                  ram_a_req;
  logic                  ram_a_rvalid;
  logic [DATA_WIDTH-1:0] ram_a_rdata;
  logic                  gpio_req;
  logic                  gpio_rvalid;
  logic [DATA_WIDTH-1:0] gpio_rdata;

  // fetch strobe into port b
  logic                  ram_b_req;

  data_bus u_data_bus (
    .clk_sys_i    (clk_sys_i),
    .rst_sys_ni   (rst_sys_ni),
    .data_req_i   (data_req_i),
    .data_addr_i  (data_addr_i),
    .data_we_i    (data_we_i),
    .data_be_i    (data_be_i),
    .data_wdata_i (data_wdata_i),
    .data_gnt_o   (data_gnt_o),
    .data_rvalid_o(data_rvalid_o),
    .data_rdata_o (data_rdata_o),
    .data_err_o   (data_err_o),
    .ram_rvalid_i (ram_a_rvalid),
    .ram_rdata_i  (ram_a_rdata),
    .gpio_rvalid_i(gpio_rvalid),
    .gpio_rdata_i (gpio_rdata),
    .ram_req_o    (ram_a_req),
    .gpio_req_o   (gpio_req),
    .dev_addr_o   (dev_addr),
    .dev_we_o     (dev_we),
    .dev_be_o     (dev_be),
    .dev_wdata_o  (dev_wdata)
  );

  instr_fetch u_instr_fetch (
    .clk_sys_i     (clk_sys_i),
    .rst_sys_ni    (rst_sys_ni),
    .instr_req_i   (instr_req_i),
    .instr_addr_i  (instr_addr_i),
    .instr_gnt_o   (instr_gnt_o),
    .instr_rvalid_o(instr_rvalid_o),
    .ram_req_o     (ram_b_req)
  );

  // port a for data, port b for fetch
  ram_2p u_ram (
    .clk_sys_i (clk_sys_i),
    .rst_sys_ni(rst_sys_ni),
    .a_req_i   (ram_a_req),
    .a_we_i    (dev_we),
    .a_be_i    (dev_be),
    .a_addr_i  (dev_addr),
    .a_wdata_i (dev_wdata),
    .a_rvalid_o(ram_a_rvalid),
    .a_rdata_o (ram_a_rdata),
    .b_req_i   (ram_b_req),
    .b_addr_i  (instr_addr_i),
    .b_rdata_o (instr_rdata_o)
  );

  gpio u_gpio (
    .clk_sys_i (clk_sys_i),
    .rst_sys_ni(rst_sys_ni),
    .req_i     (gpio_req),
    .addr_i    (dev_addr),
    .we_i      (dev_we),
    .be_i      (dev_be),
    .wdata_i   (dev_wdata),
    .rvalid_o  (gpio_rvalid),
    .rdata_o   (gpio_rdata),
    .gp_i      (gp_i),
    .gp_o      (gp_o)
  );

endmodule

`default_nettype wire

// ==== include/tb_ref_model.svh ====
// reference model of the ram contents and the gpio output register
// included inside the testbench module after the sys_pkg import
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

// sparse ram image, word index as key
logic [DATA_WIDTH-1:0] model_ram [logic [RAM_AW-1:0]];

// expected gp_o
logic [GPO_WIDTH-1:0] model_gpo = '0;

// same window decode as the data bus
function automatic bus_device_e model_decode(input logic [ADDR_WIDTH-1:0] addr);
  if ((addr & MEM_MASK) == MEM_START) begin
    return dev_ram;
  end
  if ((addr & GPIO_MASK) == GPIO_START) begin
    return dev_gpio;
  end
  return dev_none;
endfunction

// apply a data write, unmapped writes change nothing
task automatic model_write(input logic [ADDR_WIDTH-1:0] addr, input logic [BE_WIDTH-1:0] be,
                           input logic [DATA_WIDTH-1:0] wdata);
  logic [RAM_AW-1:0]     idx;
  logic [DATA_WIDTH-1:0] word;
  idx  = addr[RAM_AW+1:2];
  word = model_ram.exists(idx) ? model_ram[idx] : '0;
  case (model_decode(addr))
    dev_ram: begin
      for (int i = 0; i < BE_WIDTH; i++) begin
        if (be[i]) word[8*i +: 8] = wdata[8*i +: 8];
      end
      model_ram[idx] = word;
    end
    dev_gpio: begin
      if ((addr & ~GPIO_MASK) == ADDR_WIDTH'(GPO_OFFSET)) begin
        for (int i = 0; i < GPO_WIDTH / 8; i++) begin
          if (be[i]) model_gpo[8*i +: 8] = wdata[8*i +: 8];
        end
      end
    end
    default: ;
  endcase
endtask

// predict read data and error for a read issued now
task automatic model_read(input logic [ADDR_WIDTH-1:0] addr, input logic [GPI_WIDTH-1:0] gpi,
                          output logic [DATA_WIDTH-1:0] rdata, output logic err);
  logic [RAM_AW-1:0]     idx;
  logic [ADDR_WIDTH-1:0] offset;
  idx    = addr[RAM_AW+1:2];
  offset = addr & ~GPIO_MASK;
  rdata  = '0;
  err    = 1'b0;
  case (model_decode(addr))
    dev_ram:  rdata = model_ram.exists(idx) ? model_ram[idx] : '0;
    dev_gpio: begin
      if (offset == ADDR_WIDTH'(GPO_OFFSET)) rdata = DATA_WIDTH'(model_gpo);
      else if (offset == ADDR_WIDTH'(GPI_OFFSET)) rdata = DATA_WIDTH'(gpi);
    end
    default:  err = 1'b1;
  endcase
endtask

`endif

// ==== testbench/tb_demo_system.sv ====
// self-checking testbench of the memory-bus subsystem
// seeded random traffic on the data and fetch ports, checked against the reference model
`timescale 1ns/1ps
`default_nettype none

module tb_demo_system
  import sys_pkg::*;
();

  localparam int RESET_CYCLES = 8;
  localparam int POOL_SIZE    = 16;
  localparam int N_WR         = 32;
  localparam int N_RD         = 32;
  localparam int N_FETCH      = 32;
  localparam int N_GPIO       = 16;
  localparam int N_UNMAP      = 16;
  localparam int N_MIX        = 64;
  // every test ends with two drain cycles
  localparam int TEST_CYCLES  = (RESET_CYCLES + 3) + (POOL_SIZE + N_WR + N_RD + 2) +
                                (N_FETCH + 2) + (3 * N_GPIO + 2) +
                                (N_UNMAP + POOL_SIZE + 2) + (N_MIX + 2);
  localparam int CYCLE_LIMIT  = 2 * TEST_CYCLES + RESET_CYCLES;

  logic                  clk_sys_i = 1'b0;
  logic                  rst_sys_ni;
  logic                  data_req_i;
  logic [ADDR_WIDTH-1:0] data_addr_i;
  logic                  data_we_i;
  logic [BE_WIDTH-1:0]   data_be_i;
  logic [DATA_WIDTH-1:0] data_wdata_i;
  logic                  data_gnt_o;
  logic                  data_rvalid_o;
  logic [DATA_WIDTH-1:0] data_rdata_o;
  logic                  data_err_o;
  logic                  instr_req_i;
  logic [ADDR_WIDTH-1:0] instr_addr_i;
  logic                  instr_gnt_o;
  logic                  instr_rvalid_o;
  logic [DATA_WIDTH-1:0] instr_rdata_o;
  logic [GPI_WIDTH-1:0]  gp_i;
  logic [GPO_WIDTH-1:0]  gp_o;

  `include "tb_ref_model.svh"

  integer seed = 32'ha9bc_4631;
  int     cycles = 0;
  int     errors = 0;
  int     err_mark = 0;
  int     tests_run = 0;
  int     tests_failed = 0;

  // ram words the traffic is confined to
  logic [RAM_AW-1:0] pool [POOL_SIZE];

  // expectation of the request driven this cycle
  logic                  pend_valid = 1'b0;
  logic                  pend_err = 1'b0;
  logic                  pend_chk = 1'b0;
  logic [DATA_WIDTH-1:0] pend_rdata = '0;
  logic                  ipend_gnt = 1'b0;
  logic [DATA_WIDTH-1:0] ipend_rdata = '0;
  // expectation of the response due this cycle
  logic                  resp_valid = 1'b0;
  logic                  resp_err = 1'b0;
  logic                  resp_chk = 1'b0;
  logic [DATA_WIDTH-1:0] resp_rdata = '0;
  logic                  iresp_valid = 1'b0;
  logic [DATA_WIDTH-1:0] iresp_rdata = '0;
  logic [GPO_WIDTH-1:0]  gpo_prev = '0;

  demo_system_top DUT (.*);

  always #4 clk_sys_i = ~clk_sys_i;

  function automatic logic [31:0] rand_word();
    return $random(seed);
  endfunction

  function automatic logic [ADDR_WIDTH-1:0] pool_addr(input int k);
    return MEM_START | (ADDR_WIDTH'(pool[k]) << 2);
  endfunction

  function automatic logic [ADDR_WIDTH-1:0] random_pool_addr();
    return pool_addr(int'($unsigned($random(seed)) % POOL_SIZE));
  endfunction

  // redraw until no window matches
  function automatic logic [ADDR_WIDTH-1:0] unmapped_addr();
    logic [ADDR_WIDTH-1:0] a;
    a = $random(seed);
    while (model_decode(a) != dev_none) begin
      a = $random(seed);
    end
    return a;
  endfunction

  // unmapped address whose low bits alias a pool word or the output register
  // a stray device strobe would then hit something the model can see
  function automatic logic [ADDR_WIDTH-1:0] aliased_unmapped_addr(input logic to_gpo);
    logic [ADDR_WIDTH-1:0] a;
    logic [ADDR_WIDTH-1:0] p;
    a = MEM_START;
    while (model_decode(a) != dev_none) begin
      a = $random(seed);
      p = random_pool_addr();
      if (to_gpo) begin
        a = (a & GPIO_MASK) | ADDR_WIDTH'(GPO_OFFSET);
      end else begin
        a = (a & MEM_MASK) | (p & ~MEM_MASK);
      end
    end
    return a;
  endfunction

  task automatic report_mismatch(input string name, input logic [31:0] exp_val,
                                 input logic [31:0] act_val);
    errors++;
    $display("ERROR %s expected 0x%h got 0x%h", name, exp_val, act_val);
  endtask

  // one clock of stimulus, expectations taken from the model at request time
  task automatic drive_cycle(input logic d_req, input logic d_we,
                             input logic [ADDR_WIDTH-1:0] d_addr, input logic [BE_WIDTH-1:0] d_be,
                             input logic [DATA_WIDTH-1:0] d_wdata, input logic i_req,
                             input logic [ADDR_WIDTH-1:0] i_addr);
    logic [31:0] r;
    logic        unused_err;
    @(posedge clk_sys_i);
    #1;
    r = $random(seed);
    gp_i         = r[GPI_WIDTH-1:0];
    data_req_i   = d_req;
    data_we_i    = d_we;
    data_addr_i  = d_addr;
    data_be_i    = d_be;
    data_wdata_i = d_wdata;
    instr_req_i  = i_req;
    instr_addr_i = i_addr;
    // fetch sees ram before this cycle's data write
    ipend_gnt = i_req && (model_decode(i_addr) == dev_ram);
    model_read(i_addr, gp_i, ipend_rdata, unused_err);
    pend_valid = d_req;
    pend_err   = 1'b0;
    pend_chk   = 1'b0;
    if (d_req) begin
      model_read(d_addr, gp_i, pend_rdata, pend_err);
      pend_chk = !d_we || pend_err;
      if (d_we) begin
        model_write(d_addr, d_be, d_wdata);
      end
    end
  endtask

  task automatic idle_cycle();
    drive_cycle(1'b0, 1'b0, '0, '0, '0, 1'b0, '0);
  endtask

  // drains the last response, then one line per test
  task automatic finish_test(input string name);
    int n;
    idle_cycle();
    idle_cycle();
    n = errors - err_mark;
    err_mark = errors;
    tests_run++;
    if (n != 0) begin
      tests_failed++;
      $display("%s: FAILED with %0d errors", name, n);
    end else begin
      $display("%s: ok", name);
    end
  endtask

  // response checks, midway between edges where outputs are settled
  always @(negedge clk_sys_i) begin
    if (data_gnt_o !== data_req_i) begin
      report_mismatch("data_gnt_o", 32'(data_req_i), 32'(data_gnt_o));
    end
    if (instr_gnt_o !== ipend_gnt) begin
      report_mismatch("instr_gnt_o", 32'(ipend_gnt), 32'(instr_gnt_o));
    end
    if (data_rvalid_o !== resp_valid) begin
      errors++;
      if (resp_valid) begin
        $display("data response missing one cycle after its request");
      end else begin
        $display("data response seen with no request in the cycle before");
      end
    end else if (resp_valid) begin
      if (data_err_o !== resp_err) begin
        report_mismatch("data_err_o", 32'(resp_err), 32'(data_err_o));
      end
      if (resp_chk && data_rdata_o !== resp_rdata) begin
        report_mismatch("data_rdata_o", resp_rdata, data_rdata_o);
      end
    end
    if (instr_rvalid_o !== iresp_valid) begin
      errors++;
      if (iresp_valid) begin
        $display("fetch response missing one cycle after its grant");
      end else begin
        $display("fetch response seen with no grant in the cycle before");
      end
    end else if (iresp_valid && instr_rdata_o !== iresp_rdata) begin
      report_mismatch("instr_rdata_o", iresp_rdata, instr_rdata_o);
    end
    if (gp_o !== gpo_prev) begin
      report_mismatch("gp_o", 32'(gpo_prev), 32'(gp_o));
    end
    // this cycle's request answers at the next check
    resp_valid  = pend_valid;
    resp_err    = pend_err;
    resp_chk    = pend_chk;
    resp_rdata  = pend_rdata;
    iresp_valid = ipend_gnt;
    iresp_rdata = ipend_rdata;
    gpo_prev    = model_gpo;
  end

  // run limit
  always @(posedge clk_sys_i) begin
    cycles++;
    if (cycles > CYCLE_LIMIT) begin
      $display("run stopped after %0d cycles without finishing", CYCLE_LIMIT);
      $display("Test failed");
      $finish;
    end
  end

  initial begin
    logic [31:0]           r;
    logic [ADDR_WIDTH-1:0] a;
    rst_sys_ni   = 1'b0;
    data_req_i   = 1'b0;
    data_addr_i  = '0;
    data_we_i    = 1'b0;
    data_be_i    = '0;
    data_wdata_i = '0;
    instr_req_i  = 1'b0;
    instr_addr_i = '0;
    gp_i         = '0;
    for (int k = 0; k < POOL_SIZE; k++) begin
      r = rand_word();
      pool[k] = r[RAM_AW-1:0];
    end

    // 1: outputs quiet through reset and just after
    repeat (RESET_CYCLES) begin
      @(posedge clk_sys_i);
      #2;
      if (data_rvalid_o !== 1'b0) report_mismatch("data_rvalid_o", 32'h0, 32'(data_rvalid_o));
      if (instr_rvalid_o !== 1'b0) report_mismatch("instr_rvalid_o", 32'h0, 32'(instr_rvalid_o));
      if (gp_o !== '0) report_mismatch("gp_o", 32'h0, 32'(gp_o));
    end
    rst_sys_ni = 1'b1;
    idle_cycle();
    finish_test("reset values");

    // 2: define every pool word, then byte writes, then back-to-back reads
    for (int k = 0; k < POOL_SIZE; k++) begin
      drive_cycle(1'b1, 1'b1, pool_addr(k), 4'hf, rand_word(), 1'b0, '0);
    end
    for (int k = 0; k < N_WR; k++) begin
      r = rand_word();
      drive_cycle(1'b1, 1'b1, random_pool_addr(), r[3:0], rand_word(), 1'b0, '0);
    end
    for (int k = 0; k < N_RD; k++) begin
      drive_cycle(1'b1, 1'b0, random_pool_addr(), 4'hf, '0, 1'b0, '0);
    end
    finish_test("ram write and read");

    // 3: fetches beside data writes, some outside the ram window
    for (int k = 0; k < N_FETCH; k++) begin
      r = rand_word();
      a = (r[2:0] == 3'd0) ? unmapped_addr() : random_pool_addr();
      drive_cycle(1'b1, 1'b1, random_pool_addr(), r[7:4], rand_word(), 1'b1, a);
    end
    finish_test("instruction fetch");

    // 4: output register write and readback, input register read
    for (int k = 0; k < N_GPIO; k++) begin
      r = rand_word();
      drive_cycle(1'b1, 1'b1, GPIO_START + GPO_OFFSET, r[3:0], rand_word(), 1'b0, '0);
      drive_cycle(1'b1, 1'b0, GPIO_START + GPO_OFFSET, 4'hf, '0, 1'b0, '0);
      drive_cycle(1'b1, 1'b0, GPIO_START + GPI_OFFSET, 4'hf, '0, 1'b0, '0);
    end
    finish_test("gpio");

    // 5: unmapped accesses aliasing pool words or the output register,
    // then the pool read back untouched
    for (int k = 0; k < N_UNMAP; k++) begin
      r = rand_word();
      a = aliased_unmapped_addr(r[1]);
      drive_cycle(1'b1, r[0], a, r[7:4], rand_word(), 1'b0, '0);
    end
    for (int k = 0; k < POOL_SIZE; k++) begin
      drive_cycle(1'b1, 1'b0, pool_addr(k), 4'hf, '0, 1'b0, '0);
    end
    finish_test("unmapped error");

    // 6: one random request of any kind per cycle
    for (int k = 0; k < N_MIX; k++) begin
      r = rand_word();
      if (r[2:0] < 3'd3) begin
        a = random_pool_addr();
      end else if (r[2:0] < 3'd5) begin
        case (r[9:8])
          2'd0:    a = GPIO_START + GPI_OFFSET;
          2'd1:    a = GPIO_START + 32'h10;
          default: a = GPIO_START + GPO_OFFSET;
        endcase
      end else begin
        a = unmapped_addr();
      end
      drive_cycle(1'b1, r[3], a, r[7:4], rand_word(), 1'b0, '0);
    end
    finish_test("mixed traffic");

    $display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== compile.f ====
+incdir+include
verilog/sys_pkg.sv
verilog/gpio.sv
verilog/ram_2p.sv
verilog/instr_fetch.sv
verilog/data_bus.sv
verilog/demo_system_top.sv
testbench/tb_demo_system.sv

// ==== Bender.yml ====
package:
  name: demo_system_membus

sources:
  - verilog/sys_pkg.sv
  - verilog/gpio.sv
  - verilog/ram_2p.sv
  - verilog/instr_fetch.sv
  - verilog/data_bus.sv
  - verilog/demo_system_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - testbench/tb_demo_system.sv
